// File: rtl/dma_ctrl_pkg.sv
/* Register map and field types shared by the DMA control plane.
   Modules name these types in their ports and import the package in their bodies. */
package dma_ctrl_pkg;

    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_word_t;
    typedef logic [63:0] pcie_addr_t;
    typedef logic [31:0] axi_addr_t;
    typedef logic [15:0] dma_len_t;
    typedef logic [7:0]  dma_tag_t;

    localparam reg_addr_t ADDR_DMA_ENABLE = 16'h0000;

    // descriptor bank bases, each decodes BANK_SPAN bytes
    localparam reg_addr_t ADDR_RD_BANK = 16'h0100;
    localparam reg_addr_t ADDR_WR_BANK = 16'h0200;
    localparam reg_addr_t BANK_SPAN    = 16'h0100;

    // offsets inside a bank
    localparam reg_addr_t OFS_PCIE_LO = 16'h0000;
    localparam reg_addr_t OFS_PCIE_HI = 16'h0004;
    localparam reg_addr_t OFS_AXI     = 16'h0008;
    localparam reg_addr_t OFS_LEN     = 16'h0010;
    // a write here launches the descriptor
    localparam reg_addr_t OFS_TAG     = 16'h0014;
    localparam reg_addr_t OFS_STATUS  = 16'h0018;

    // frame counters rq, rc, cq, cc, one word apart
    localparam reg_addr_t ADDR_COUNT_BASE = 16'h0400;

    // set in a status word when a completion is pending
    localparam int STATUS_VALID_BIT = 31;

endpackage

// File: rtl/host_reg_if.sv
/* Register bus slave for the DMA control plane. Decodes writes to the banks and the
   enable register, and returns bank status, frame counts or the enable bit on reads. */
`timescale 1ns/1ns

module host_reg_if #(
    parameter int STREAM_COUNT = 4
) (
    input  logic                                      clk,
    input  logic                                      rst,

    input  dma_ctrl_pkg::reg_addr_t                   reg_wr_addr,
    input  dma_ctrl_pkg::reg_word_t                   reg_wr_data,
    input  logic                                      reg_wr_valid,
    output logic                                      reg_wr_ready,
    output logic                                      reg_wr_resp_valid,
    input  logic                                      reg_wr_resp_ready,

    input  dma_ctrl_pkg::reg_addr_t                   reg_rd_addr,
    input  logic                                      reg_rd_valid,
    output logic                                      reg_rd_ready,
    output dma_ctrl_pkg::reg_word_t                   reg_rd_data,
    output logic                                      reg_rd_data_valid,
    input  logic                                      reg_rd_data_ready,

    output logic                                      rd_bank_wr,
    output logic                                      wr_bank_wr,
    output dma_ctrl_pkg::reg_addr_t                   bank_ofs,
    output dma_ctrl_pkg::reg_word_t                   bank_data,
    output logic                                      rd_bank_status_rd,
    output logic                                      wr_bank_status_rd,
    input  dma_ctrl_pkg::reg_word_t                   rd_status_word,
    input  dma_ctrl_pkg::reg_word_t                   wr_status_word,
    input  dma_ctrl_pkg::reg_word_t [STREAM_COUNT-1:0] counts,

    output logic                                      dma_enable
);
    import dma_ctrl_pkg::*;

    localparam reg_addr_t BANK_MASK = ~(BANK_SPAN - 16'd1);

    logic      wr_fire;
    logic      rd_fire;
    reg_addr_t wr_word;
    reg_addr_t rd_word;
    reg_addr_t wr_base;
    reg_word_t rd_mux;

    // one transaction in flight per channel
    assign reg_wr_ready = !reg_wr_resp_valid;
    assign reg_rd_ready = !reg_rd_data_valid;
    assign wr_fire = reg_wr_valid && reg_wr_ready;
    assign rd_fire = reg_rd_valid && reg_rd_ready;

    // byte lanes ignored
    assign wr_word = {reg_wr_addr[15:2], 2'b00};
    assign rd_word = {reg_rd_addr[15:2], 2'b00};
    assign wr_base = wr_word & BANK_MASK;

    // banks get the word address and pick their own field
    assign rd_bank_wr = wr_fire && (wr_base == ADDR_RD_BANK);
    assign wr_bank_wr = wr_fire && (wr_base == ADDR_WR_BANK);
    assign bank_ofs   = wr_word;
    assign bank_data  = reg_wr_data;

    assign rd_bank_status_rd = rd_fire && (rd_word == ADDR_RD_BANK + OFS_STATUS);
    assign wr_bank_status_rd = rd_fire && (rd_word == ADDR_WR_BANK + OFS_STATUS);

    always_comb begin
        rd_mux = '0;
        if (rd_word == ADDR_DMA_ENABLE) begin
            rd_mux = reg_word_t'(dma_enable);
        end
        if (rd_word == ADDR_RD_BANK + OFS_STATUS) begin
            rd_mux = rd_status_word;
        end
        if (rd_word == ADDR_WR_BANK + OFS_STATUS) begin
            rd_mux = wr_status_word;
        end
        for (int i = 0; i < STREAM_COUNT; i++) begin
            if (rd_word == ADDR_COUNT_BASE + reg_addr_t'(4 * i)) begin
                rd_mux = counts[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_wr_resp_valid <= 1'b0;
            reg_rd_data_valid <= 1'b0;
            dma_enable        <= 1'b0;
        end else begin
            reg_wr_resp_valid <= wr_fire || (reg_wr_resp_valid && !reg_wr_resp_ready);
            reg_rd_data_valid <= rd_fire || (reg_rd_data_valid && !reg_rd_data_ready);
            if (wr_fire && wr_word == ADDR_DMA_ENABLE) begin
                dma_enable <= reg_wr_data[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            reg_rd_data <= rd_mux;
        end
    end

    // a response the host has not taken blocks the next write
    assert property (@(posedge clk) disable iff (rst)
        reg_wr_resp_valid && !reg_wr_resp_ready |=> !(reg_wr_valid && reg_wr_ready));

endmodule

// File: rtl/dma_desc_bank.sv
/* One DMA descriptor bank. Holds the descriptor fields written over the register bus,
   launches on a tag write and pops engine status when the host reads it. */
`timescale 1ns/1ns

module dma_desc_bank #(
    parameter dma_ctrl_pkg::reg_addr_t BASE_ADDR = dma_ctrl_pkg::ADDR_RD_BANK
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     bank_wr,
    input  dma_ctrl_pkg::reg_addr_t  bank_ofs,
    input  dma_ctrl_pkg::reg_word_t  bank_data,
    input  logic                     bank_status_rd,
    output dma_ctrl_pkg::reg_word_t  status_word,

    output dma_ctrl_pkg::pcie_addr_t desc_pcie_addr,
    output dma_ctrl_pkg::axi_addr_t  desc_axi_addr,
    output dma_ctrl_pkg::dma_len_t   desc_len,
    output dma_ctrl_pkg::dma_tag_t   desc_tag,
    output logic                     desc_valid,
    input  logic                     desc_ready,

    input  dma_ctrl_pkg::dma_tag_t   status_tag,
    input  logic                     status_valid,
    output logic                     status_ready
);
    import dma_ctrl_pkg::*;

    reg_addr_t local_ofs;
    logic      field_wr;

    assign local_ofs = bank_ofs - BASE_ADDR;
    // fields frozen while the engine has not taken the descriptor
    assign field_wr = bank_wr && !desc_valid;

    always_ff @(posedge clk) begin
        if (field_wr) begin
            case (local_ofs)
                OFS_PCIE_LO: desc_pcie_addr[31:0] <= bank_data;
                OFS_PCIE_HI: desc_pcie_addr[63:32] <= bank_data;
                OFS_AXI:     desc_axi_addr <= bank_data;
                OFS_LEN:     desc_len <= bank_data[15:0];
                OFS_TAG:     desc_tag <= bank_data[7:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            desc_valid   <= 1'b0;
            status_ready <= 1'b0;
        end else begin
            if (desc_valid && desc_ready) begin
                desc_valid <= 1'b0;
            end else if (field_wr && local_ofs == OFS_TAG) begin
                desc_valid <= 1'b1;
            end
            // pop only what the host actually saw
            status_ready <= bank_status_rd && status_valid;
        end
    end

    assign status_word = status_valid ?
        (reg_word_t'(status_tag) | (reg_word_t'(1) << STATUS_VALID_BIT)) : '0;

    // engine may sample the fields any cycle before it accepts
    assert property (@(posedge clk) disable iff (rst)
        desc_valid && !desc_ready |=> $stable(desc_pcie_addr) && $stable(desc_axi_addr)
            && $stable(desc_len) && $stable(desc_tag));

    // each pop needs a new status read, and the bus holds off reads while data is pending
    assert property (@(posedge clk) disable iff (rst)
        status_ready |=> !status_ready);

    // slave decode must agree with this bank's base
    assert property (@(posedge clk) disable iff (rst)
        bank_wr |-> local_ofs < BANK_SPAN);

endmodule

// File: rtl/stream_frame_counters.sv
/* Counts completed frames on the monitored PCIe streams, one wrapping word per stream.
   A frame ends on a cycle with valid, ready and last all high. */
`timescale 1ns/1ns

module stream_frame_counters #(
    parameter int STREAM_COUNT = 4
) (
    input  logic                                       clk,
    input  logic                                       rst,

    input  logic [STREAM_COUNT-1:0]                    stream_valid,
    input  logic [STREAM_COUNT-1:0]                    stream_ready,
    input  logic [STREAM_COUNT-1:0]                    stream_last,

    output dma_ctrl_pkg::reg_word_t [STREAM_COUNT-1:0] counts
);

    logic [STREAM_COUNT-1:0] frame_end;

    assign frame_end = stream_valid & stream_ready & stream_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else begin
            for (int i = 0; i < STREAM_COUNT; i++) begin
                // wraps silently at 2^32
                if (frame_end[i]) begin
                    counts[i] <= counts[i] + 32'd1;
                end
            end
        end
    end

endmodule

// File: rtl/error_pulse_merge.sv
/* Merges error pulses from several sources into one output. Every input pulse is
   counted and later replayed as a single-cycle pulse followed by at least one low cycle. */
`timescale 1ns/1ns

module error_pulse_merge #(
    parameter int ERR_SOURCES = 3,
    parameter int PEND_WIDTH  = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [ERR_SOURCES-1:0] pulse_in,
    output logic                   pulse_out
);

    localparam int POP_WIDTH = $clog2(ERR_SOURCES + 1);
    localparam int SUM_WIDTH = PEND_WIDTH + POP_WIDTH;
    localparam logic [SUM_WIDTH-1:0] PEND_MAX = SUM_WIDTH'((1 << PEND_WIDTH) - 1);

    logic [PEND_WIDTH-1:0] pend;
    logic [POP_WIDTH-1:0]  pop;
    logic [SUM_WIDTH-1:0]  sum;
    logic                  emit;

    // one unit leaves per pulse, never two cycles in a row
    assign emit = (pend != '0) && !pulse_out;

    always_comb begin
        pop = '0;
        for (int i = 0; i < ERR_SOURCES; i++) begin
            pop = pop + POP_WIDTH'(pulse_in[i]);
        end
        sum = SUM_WIDTH'(pend) + SUM_WIDTH'(pop) - SUM_WIDTH'(emit);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend      <= '0;
            pulse_out <= 1'b0;
        end else begin
            pulse_out <= emit;
            // excess errors are lost once the count is full
            if (sum > PEND_MAX) begin
                pend <= PEND_MAX[PEND_WIDTH-1:0];
            end else begin
                pend <= sum[PEND_WIDTH-1:0];
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        pulse_out |=> !pulse_out);

endmodule

// File: rtl/dma_ctrl_top.sv
/* Control plane of the PCIe DMA example core. Connects the register bus slave to the
   read and write descriptor banks, the stream frame counters and the error mergers. */
`timescale 1ns/1ns

module dma_ctrl_top #(
    parameter int STREAM_COUNT = 4,
    parameter int ERR_SOURCES  = 3,
    parameter int PEND_WIDTH   = 4
) (
    input  logic                     clk,
    input  logic                     rst,

    input  dma_ctrl_pkg::reg_addr_t  reg_wr_addr,
    input  dma_ctrl_pkg::reg_word_t  reg_wr_data,
    input  logic                     reg_wr_valid,
    output logic                     reg_wr_ready,
    output logic                     reg_wr_resp_valid,
    input  logic                     reg_wr_resp_ready,
    input  dma_ctrl_pkg::reg_addr_t  reg_rd_addr,
    input  logic                     reg_rd_valid,
    output logic                     reg_rd_ready,
    output dma_ctrl_pkg::reg_word_t  reg_rd_data,
    output logic                     reg_rd_data_valid,
    input  logic                     reg_rd_data_ready,

    output dma_ctrl_pkg::pcie_addr_t rd_desc_pcie_addr,
    output dma_ctrl_pkg::axi_addr_t  rd_desc_axi_addr,
    output dma_ctrl_pkg::dma_len_t   rd_desc_len,
    output dma_ctrl_pkg::dma_tag_t   rd_desc_tag,
    output logic                     rd_desc_valid,
    input  logic                     rd_desc_ready,
    output dma_ctrl_pkg::pcie_addr_t wr_desc_pcie_addr,
    output dma_ctrl_pkg::axi_addr_t  wr_desc_axi_addr,
    output dma_ctrl_pkg::dma_len_t   wr_desc_len,
    output dma_ctrl_pkg::dma_tag_t   wr_desc_tag,
    output logic                     wr_desc_valid,
    input  logic                     wr_desc_ready,

    input  dma_ctrl_pkg::dma_tag_t   rd_status_tag,
    input  logic                     rd_status_valid,
    output logic                     rd_status_ready,
    input  dma_ctrl_pkg::dma_tag_t   wr_status_tag,
    input  logic                     wr_status_valid,
    output logic                     wr_status_ready,

    output logic                     dma_enable,
    output logic                     irq,

    input  logic [STREAM_COUNT-1:0]  stream_valid,
    input  logic [STREAM_COUNT-1:0]  stream_ready,
    input  logic [STREAM_COUNT-1:0]  stream_last,

    input  logic [ERR_SOURCES-1:0]   err_cor_in,
    input  logic [ERR_SOURCES-1:0]   err_uncor_in,
    output logic                     err_cor,
    output logic                     err_uncor
);
    import dma_ctrl_pkg::*;

    logic                         rd_bank_wr;
    logic                         wr_bank_wr;
    reg_addr_t                    bank_ofs;
    reg_word_t                    bank_data;
    logic                         rd_bank_status_rd;
    logic                         wr_bank_status_rd;
    reg_word_t                    rd_status_word;
    reg_word_t                    wr_status_word;
    reg_word_t [STREAM_COUNT-1:0] counts;

    // raised while either engine has a completion waiting
    assign irq = rd_status_valid || wr_status_valid;

    host_reg_if #(
        .STREAM_COUNT(STREAM_COUNT)
    ) host_reg_if_inst (
        .clk(clk),
        .rst(rst),
        .reg_wr_addr(reg_wr_addr),
        .reg_wr_data(reg_wr_data),
        .reg_wr_valid(reg_wr_valid),
        .reg_wr_ready(reg_wr_ready),
        .reg_wr_resp_valid(reg_wr_resp_valid),
        .reg_wr_resp_ready(reg_wr_resp_ready),
        .reg_rd_addr(reg_rd_addr),
        .reg_rd_valid(reg_rd_valid),
        .reg_rd_ready(reg_rd_ready),
        .reg_rd_data(reg_rd_data),
        .reg_rd_data_valid(reg_rd_data_valid),
        .reg_rd_data_ready(reg_rd_data_ready),
        .rd_bank_wr(rd_bank_wr),
        .wr_bank_wr(wr_bank_wr),
        .bank_ofs(bank_ofs),
        .bank_data(bank_data),
        .rd_bank_status_rd(rd_bank_status_rd),
        .wr_bank_status_rd(wr_bank_status_rd),
        .rd_status_word(rd_status_word),
        .wr_status_word(wr_status_word),
        .counts(counts),
        .dma_enable(dma_enable)
    );

    dma_desc_bank #(
        .BASE_ADDR(ADDR_RD_BANK)
    ) rd_bank_inst (
        .clk(clk),
        .rst(rst),
        .bank_wr(rd_bank_wr),
        .bank_ofs(bank_ofs),
        .bank_data(bank_data),
        .bank_status_rd(rd_bank_status_rd),
        .status_word(rd_status_word),
        .desc_pcie_addr(rd_desc_pcie_addr),
        .desc_axi_addr(rd_desc_axi_addr),
        .desc_len(rd_desc_len),
        .desc_tag(rd_desc_tag),
        .desc_valid(rd_desc_valid),
        .desc_ready(rd_desc_ready),
        .status_tag(rd_status_tag),
        .status_valid(rd_status_valid),
        .status_ready(rd_status_ready)
    );

    dma_desc_bank #(
        .BASE_ADDR(ADDR_WR_BANK)
    ) wr_bank_inst (
        .clk(clk),
        .rst(rst),
        .bank_wr(wr_bank_wr),
        .bank_ofs(bank_ofs),
        .bank_data(bank_data),
        .bank_status_rd(wr_bank_status_rd),
        .status_word(wr_status_word),
        .desc_pcie_addr(wr_desc_pcie_addr),
        .desc_axi_addr(wr_desc_axi_addr),
        .desc_len(wr_desc_len),
        .desc_tag(wr_desc_tag),
        .desc_valid(wr_desc_valid),
        .desc_ready(wr_desc_ready),
        .status_tag(wr_status_tag),
        .status_valid(wr_status_valid),
        .status_ready(wr_status_ready)
    );

    // stream order rq, rc, cq, cc
    stream_frame_counters #(
        .STREAM_COUNT(STREAM_COUNT)
    ) frame_cnt_inst (
        .clk(clk),
        .rst(rst),
        .stream_valid(stream_valid),
        .stream_ready(stream_ready),
        .stream_last(stream_last),
        .counts(counts)
    );

    error_pulse_merge #(
        .ERR_SOURCES(ERR_SOURCES),
        .PEND_WIDTH(PEND_WIDTH)
    ) err_cor_inst (
        .clk(clk),
        .rst(rst),
        .pulse_in(err_cor_in),
        .pulse_out(err_cor)
    );

    error_pulse_merge #(
        .ERR_SOURCES(ERR_SOURCES),
        .PEND_WIDTH(PEND_WIDTH)
    ) err_uncor_inst (
        .clk(clk),
        .rst(rst),
        .pulse_in(err_uncor_in),
        .pulse_out(err_uncor)
    );

endmodule

// File: tb/tb_dma_ctrl.sv
/* Testbench for the DMA control plane. Drives the register bus, descriptor and status
   handshakes, stream bits and error pulses, and checks responses against simple models. */
`timescale 1ns/1ns

module tb_dma_ctrl;
    import dma_ctrl_pkg::*;

    localparam int TIMEOUT = 200;

    logic clk;
    logic rst;
    reg_addr_t reg_wr_addr;
    reg_word_t reg_wr_data;
    logic reg_wr_valid, reg_wr_ready, reg_wr_resp_valid, reg_wr_resp_ready;
    reg_addr_t reg_rd_addr;
    reg_word_t reg_rd_data;
    logic reg_rd_valid, reg_rd_ready, reg_rd_data_valid, reg_rd_data_ready;
    pcie_addr_t rd_desc_pcie_addr, wr_desc_pcie_addr;
    axi_addr_t rd_desc_axi_addr, wr_desc_axi_addr;
    dma_len_t rd_desc_len, wr_desc_len;
    dma_tag_t rd_desc_tag, wr_desc_tag, rd_status_tag, wr_status_tag;
    logic rd_desc_valid, rd_desc_ready, wr_desc_valid, wr_desc_ready;
    logic rd_status_valid, rd_status_ready, wr_status_valid, wr_status_ready;
    logic dma_enable, irq, err_cor, err_uncor;
    logic [3:0] stream_valid, stream_ready, stream_last;
    logic [2:0] err_cor_in, err_uncor_in;

    // descriptor fields packed pcie, axi, len, tag
    logic [119:0] rd_desc_bits, wr_desc_bits;
    int unsigned model_count [4];
    int rd_pops, wr_pops, cor_seen, uncor_seen, cor_expect, uncor_expect;
    int unsigned lcg_state = 36482;

    assign rd_desc_bits = {rd_desc_pcie_addr, rd_desc_axi_addr, rd_desc_len, rd_desc_tag};
    assign wr_desc_bits = {wr_desc_pcie_addr, wr_desc_axi_addr, wr_desc_len, wr_desc_tag};

    dma_ctrl_top #(.STREAM_COUNT(4), .ERR_SOURCES(3), .PEND_WIDTH(4)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check_eq(input reg_word_t got, input reg_word_t exp, input string what);
        assert (got == exp) else
            abort_run($sformatf("[FAIL] %0t ns: %s is 0x%08h, expected 0x%08h",
                $time, what, got, exp));
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // monitors sample at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 4; i++) begin
                if (stream_valid[i] && stream_ready[i] && stream_last[i]) begin
                    model_count[i]++;
                end
            end
            if (rd_status_ready) rd_pops++;
            if (wr_status_ready) wr_pops++;
            if (err_cor) cor_seen++;
            if (err_uncor) uncor_seen++;
        end
    end

    assert property (@(posedge clk) disable iff (rst) err_cor |=> !err_cor)
        else abort_run("correctable error output high on two consecutive cycles");
    assert property (@(posedge clk) disable iff (rst) err_uncor |=> !err_uncor)
        else abort_run("uncorrectable error output high on two consecutive cycles");
    assert property (@(posedge clk) disable iff (rst)
        rd_desc_valid && !rd_desc_ready |=> rd_desc_valid && $stable(rd_desc_bits))
        else abort_run("read descriptor dropped or changed before it was taken");
    assert property (@(posedge clk) disable iff (rst)
        wr_desc_valid && !wr_desc_ready |=> wr_desc_valid && $stable(wr_desc_bits))
        else abort_run("write descriptor dropped or changed before it was taken");
    assert property (@(posedge clk) disable iff (rst) rd_status_ready |=> !rd_status_ready)
        else abort_run("read bank status pop lasted two cycles");
    assert property (@(posedge clk) disable iff (rst) wr_status_ready |=> !wr_status_ready)
        else abort_run("write bank status pop lasted two cycles");
    assert property (@(posedge clk) disable iff (rst)
        !(reg_wr_resp_valid && reg_wr_ready) && !(reg_rd_data_valid && reg_rd_ready))
        else abort_run("bus slave ready while a response is still pending");

    task automatic bus_write(input reg_addr_t addr, input reg_word_t data);
        int t;
        reg_wr_addr = addr;
        reg_wr_data = data;
        reg_wr_valid = 1'b1;
        t = 0;
        while (!reg_wr_ready) begin
            step();
            t++;
            if (t > TIMEOUT) abort_run("timeout waiting for reg_wr_ready");
        end
        step();
        reg_wr_valid = 1'b0;
        reg_wr_resp_ready = 1'b1;
        t = 0;
        while (!reg_wr_resp_valid) begin
            step();
            t++;
            if (t > TIMEOUT) abort_run("timeout waiting for the write response");
        end
        step();
        reg_wr_resp_ready = 1'b0;
    endtask

    task automatic bus_read(input reg_addr_t addr, output reg_word_t data);
        int t;
        reg_rd_addr = addr;
        reg_rd_valid = 1'b1;
        t = 0;
        while (!reg_rd_ready) begin
            step();
            t++;
            if (t > TIMEOUT) abort_run("timeout waiting for reg_rd_ready");
        end
        step();
        reg_rd_valid = 1'b0;
        t = 0;
        while (!reg_rd_data_valid) begin
            step();
            t++;
            if (t > TIMEOUT) abort_run("timeout waiting for read data");
        end
        data = reg_rd_data;
        reg_rd_data_ready = 1'b1;
        step();
        reg_rd_data_ready = 0;
    endtask

    task automatic expect_read(input reg_addr_t addr, input reg_word_t exp, input string what);
        reg_word_t data;
        bus_read(addr, data);
        check_eq(data, exp, what);
    endtask

    task automatic run_bank(input bit wr_side, input reg_addr_t base, input pcie_addr_t pcie,
            input axi_addr_t axi, input dma_len_t len, input dma_tag_t tag);
        logic [119:0] exp_bits;
        int t;
        exp_bits = {pcie, axi, len, tag};
        bus_write(base + OFS_PCIE_LO, pcie[31:0]);
        bus_write(base + OFS_PCIE_HI, pcie[63:32]);
        bus_write(base + OFS_AXI, axi);
        bus_write(base + OFS_LEN, 32'(len));
        bus_write(base + OFS_TAG, 32'(tag));
        // engine still stalled so these must not land
        bus_write(base + OFS_LEN, 32'(~len));
        bus_write(base + OFS_PCIE_LO, ~pcie[31:0]);
        check_eq(32'(wr_side ? wr_desc_valid : rd_desc_valid), 32'd1, "desc_valid");
        t = 0;
        while (wr_side ? wr_desc_valid : rd_desc_valid) begin
            assert ((wr_side ? wr_desc_bits : rd_desc_bits) == exp_bits) else
                abort_run($sformatf("[FAIL] %0t ns: descriptor ports 0x%030h, expected 0x%030h",
                    $time, wr_side ? wr_desc_bits : rd_desc_bits, exp_bits));
            if (wr_side) wr_desc_ready = (lcg_next() % 4 == 0);
            else rd_desc_ready = (lcg_next() % 4 == 0);
            step();
            t++;
            if (t > TIMEOUT) abort_run("timeout waiting for the descriptor to be taken");
        end
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
    endtask

    task automatic pop_status(input bit wr_side, input reg_addr_t base, input dma_tag_t tag);
        int pops;
        if (wr_side) wr_status_valid = 1'b1;
        else rd_status_valid = 1'b1;
        // the idle side carries a different tag
        rd_status_tag = wr_side ? ~tag : tag;
        wr_status_tag = wr_side ? tag : ~tag;
        step();
        check_eq(32'(irq), 32'd1, "irq with a completion pending");
        pops = wr_side ? wr_pops : rd_pops;
        expect_read(base + OFS_STATUS, 32'h8000_0000 | {24'd0, tag}, "status word");
        step();
        check_eq(wr_side ? wr_pops : rd_pops, pops + 1, "status pops");
        rd_status_valid = 1'b0;
        wr_status_valid = 1'b0;
        step();
        check_eq(32'(irq), 32'd0, "irq after status drop");
        expect_read(base + OFS_STATUS, 32'd0, "empty status word");
        check_eq(wr_side ? wr_pops : rd_pops, pops + 1, "status pops after empty read");
    endtask

    task automatic run_errors();
        int t;
        for (int b = 0; b < 6; b++) begin
            // at most 12 units per burst stays below the pending limit
            for (int c = 0; c < 4; c++) begin
                err_cor_in = 3'(lcg_next());
                err_uncor_in = 3'(lcg_next());
                cor_expect += $countones(err_cor_in);
                uncor_expect += $countones(err_uncor_in);
                step();
            end
            err_cor_in = '0;
            err_uncor_in = '0;
            t = 0;
            while (cor_seen != cor_expect || uncor_seen != uncor_expect) begin
                step();
                t++;
                if (t > TIMEOUT) abort_run("timeout waiting for merged error pulses");
            end
        end
        repeat (20) step();
        check_eq(cor_seen, cor_expect, "correctable pulse count");
        check_eq(uncor_seen, uncor_expect, "uncorrectable pulse count");
    endtask

    task automatic run_backpressure();
        // second write waits while the response is held
        reg_wr_resp_ready = 1'b0;
        check_eq(32'(reg_wr_ready), 32'd1, "idle reg_wr_ready");
        reg_wr_addr = ADDR_DMA_ENABLE;
        reg_wr_data = 32'd0;
        reg_wr_valid = 1'b1;
        step();
        reg_wr_data = 32'd1;
        repeat (5) begin
            check_eq(32'(reg_wr_ready), 32'd0, "reg_wr_ready with response pending");
            check_eq(32'(dma_enable), 32'd0, "dma_enable during stalled write");
            step();
        end
        reg_wr_resp_ready = 1'b1;
        step();
        reg_wr_resp_ready = 1'b0;
        step();
        reg_wr_valid = 1'b0;
        check_eq(32'(dma_enable), 32'd1, "dma_enable after second write");
        reg_wr_resp_ready = 1'b1;
        step();
        reg_wr_resp_ready = 1'b0;
        // second read waits while the data is held
        reg_rd_data_ready = 1'b0;
        reg_rd_addr = ADDR_DMA_ENABLE;
        reg_rd_valid = 1'b1;
        step();
        reg_rd_addr = ADDR_COUNT_BASE;
        repeat (5) begin
            check_eq(32'(reg_rd_ready), 32'd0, "reg_rd_ready with data pending");
            check_eq(reg_rd_data, 32'd1, "held read data");
            step();
        end
        reg_rd_data_ready = 1'b1;
        step();
        reg_rd_data_ready = 1'b0;
        step();
        reg_rd_valid = 1'b0;
        check_eq(reg_rd_data, model_count[0], "second read data");
        reg_rd_data_ready = 1'b1;
        step();
        reg_rd_data_ready = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        reg_wr_addr = '0;
        reg_wr_data = '0;
        reg_wr_valid = 1'b0;
        reg_wr_resp_ready = 1'b0;
        reg_rd_addr = '0;
        reg_rd_valid = 1'b0;
        reg_rd_data_ready = 1'b0;
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
        rd_status_tag = '0;
        wr_status_tag = '0;
        rd_status_valid = 1'b0;
        wr_status_valid = 1'b0;
        stream_valid = '0;
        stream_ready = '0;
        stream_last = '0;
        err_cor_in = '0;
        err_uncor_in = '0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        check_eq(32'({reg_wr_resp_valid, reg_rd_data_valid, rd_desc_valid, wr_desc_valid,
            rd_status_ready, wr_status_ready, dma_enable, err_cor, err_uncor}), 32'd0,
            "control outputs after reset");
        expect_read(ADDR_DMA_ENABLE, 32'd0, "enable after reset");
        for (int i = 0; i < 4; i++) begin
            expect_read(ADDR_COUNT_BASE + reg_addr_t'(4 * i), 32'd0, "counter after reset");
        end

        bus_write(ADDR_DMA_ENABLE, 32'd1);
        check_eq(32'(dma_enable), 32'd1, "dma_enable");
        expect_read(ADDR_DMA_ENABLE, 32'd1, "enable readback");
        run_bank(1'b0, ADDR_RD_BANK, 64'h0123_4567_89ab_cdef, 32'h0000_8000, 16'h0400, 8'h3c);
        run_bank(1'b1, ADDR_WR_BANK, 64'hfedc_ba98_7654_3210, 32'h0001_2000, 16'h1000, 8'hc5);

        pop_status(1'b0, ADDR_RD_BANK, 8'ha5);
        pop_status(1'b1, ADDR_WR_BANK, 8'h5a);

        repeat (200) begin
            stream_valid = 4'(lcg_next());
            stream_ready = 4'(lcg_next());
            stream_last = 4'(lcg_next());
            step();
        end
        stream_valid = '0;
        step();
        for (int i = 0; i < 4; i++) begin
            expect_read(ADDR_COUNT_BASE + reg_addr_t'(4 * i), model_count[i], "frame count");
        end

        run_errors();
        run_backpressure();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: vlog.f
rtl/dma_ctrl_pkg.sv
rtl/host_reg_if.sv
rtl/dma_desc_bank.sv
rtl/stream_frame_counters.sv
rtl/error_pulse_merge.sv
rtl/dma_ctrl_top.sv
tb/tb_dma_ctrl.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_dma_ctrl
FILELIST  = vlog.f
PASS_MSG  = PASS: all tests
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the simulation output decides pass or fail
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
